//--- Bender.yml
package:
  name: acc_output

sources:
  - hw/acc_out_pkg.sv
  - hw/fifo.sv
  - hw/conf_receiver.sv
  - hw/output_queue_controller.sv
  - hw/write_ack_router.sv
  - hw/write_arbiter.sv
  - hw/acc_output_top.sv
  - target: test
    files:
      - verification/acc_output_tb.sv

//--- files.f
hw/acc_out_pkg.sv
hw/fifo.sv
hw/conf_receiver.sv
hw/output_queue_controller.sv
hw/write_ack_router.sv
hw/write_arbiter.sv
hw/acc_output_top.sv
verification/acc_output_tb.sv

//--- hw/acc_out_pkg.sv
`default_nettype none

package acc_out_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int QTD_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int CONF_ID_WIDTH = 8;
  localparam int TAG_WIDTH = 8;
  localparam int NUM_QUEUES = 2;

  // every FIFO in the design holds 2**FIFO_DEPTH_BITS entries.
  localparam int FIFO_DEPTH_BITS = 4;
  localparam int FIFO_ALMOSTFULL = 12;
  localparam int FIFO_ALMOSTEMPTY = 2;

  localparam int CONF_VALID_WIDTH = 2;
  localparam logic [CONF_VALID_WIDTH-1:0] CONF_CODE_RESET = 2'd1;
  localparam logic [CONF_VALID_WIDTH-1:0] CONF_CODE_OUT_DATA = 2'd2;

  localparam int WORDS_PER_ACK = 4; // memory acknowledges writes in groups of four.

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]    addr_base;
    logic [QTD_WIDTH-1:0]     qtd;
    logic [CONF_ID_WIDTH-1:0] queue_id;
  } conf_word_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [ADDR_WIDTH-1:0] addr;
    logic [TAG_WIDTH-1:0]  tag;   // the tag is the number of the issuing queue.
  } write_req_t;

endpackage

`default_nettype wire

//--- hw/acc_output_top.sv
`timescale 1ns/1ps
`default_nettype none

module acc_output_top
  import acc_out_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_internal,
  input  logic [NUM_QUEUES-1:0]                start,
  input  logic [CONF_VALID_WIDTH-1:0]          conf_valid,
  input  conf_word_t                           conf,
  input  logic [NUM_QUEUES-1:0]                user_write,
  input  logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0] user_data,
  input  logic                                 mem_available,
  input  logic                                 mem_ack_valid,
  input  logic [TAG_WIDTH-1:0]                 mem_ack_tag,
  output logic [NUM_QUEUES-1:0]                user_available,
  output logic                                 mem_request_write,
  output write_req_t                           mem_write_data,
  output logic [NUM_QUEUES-1:0]                has_wr_pending,
  output logic [NUM_QUEUES-1:0]                done
);

  logic [NUM_QUEUES-1:0] ack;
  logic [NUM_QUEUES-1:0] available_write;
  logic [NUM_QUEUES-1:0] request_write;
  write_req_t [NUM_QUEUES-1:0] write_data;

  write_ack_router ack_router (
    .clk(clk),
    .rst_internal(rst_internal),
    .mem_ack_valid(mem_ack_valid),
    .mem_ack_tag(mem_ack_tag),
    .ack(ack)
  );

  for (genvar i = 0; i < NUM_QUEUES; i++) begin : gen_queue
    output_queue_controller #(
      .ID_QUEUE(i)
    ) queue_ctrl (
      .clk(clk),
      .rst_internal(rst_internal),
      .start(start[i]),
      .conf_valid(conf_valid),
      .conf(conf),
      .available_write(available_write[i]),
      .ack(ack[i]),
      .user_write(user_write[i]),
      .user_data(user_data[i]),
      .user_available(user_available[i]),
      .request_write(request_write[i]),
      .write_data(write_data[i]),
      .has_wr_pending(has_wr_pending[i]),
      .done(done[i])
    );
  end

  write_arbiter arbiter (
    .clk(clk),
    .rst_internal(rst_internal),
    .request_write(request_write),
    .write_data(write_data),
    .mem_available(mem_available),
    .available_write(available_write),
    .mem_request_write(mem_request_write),
    .mem_write_data(mem_write_data)
  );

endmodule

`default_nettype wire

//--- hw/conf_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module conf_receiver
  import acc_out_pkg::*;
#(
  parameter int ID_QUEUE = 0
) (
  input  logic                        clk,
  input  logic                        rst_internal,
  input  logic [CONF_VALID_WIDTH-1:0] conf_valid,
  input  conf_word_t                  conf,
  output logic                        conf_out_valid,
  output conf_word_t                  conf_out,
  output logic                        queue_rst
);

  logic conf_match;
  logic conf_rst;

  // only output-queue words addressed to this queue are taken.
  assign conf_match = (conf_valid == CONF_CODE_OUT_DATA) &&
                      (conf.queue_id == CONF_ID_WIDTH'(ID_QUEUE));

  // the queue stays in reset for the whole global reset and for one cycle after a reset code.
  assign queue_rst = rst_internal || conf_rst;

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      conf_out_valid <= 1'b0;
      conf_rst <= 1'b0;
    end else begin
      conf_out_valid <= conf_match;
      conf_rst <= (conf_valid == CONF_CODE_RESET);
    end
  end

  always_ff @(posedge clk) begin
    if (conf_match) begin
      conf_out <= conf;
    end
  end

endmodule

`default_nettype wire

//--- hw/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter type payload_t = logic [31:0],
  parameter int FIFO_DEPTH_BITS = 4,
  parameter int ALMOSTFULL_THRESHOLD = 12,
  parameter int ALMOSTEMPTY_THRESHOLD = 2
) (
  input  logic                     clk,
  input  logic                     rst_internal,
  input  logic                     we,
  input  payload_t                 din,
  input  logic                     re,
  output logic                     valid,
  output payload_t                 dout,
  output logic [FIFO_DEPTH_BITS:0] count,
  output logic                     empty,
  output logic                     full,
  output logic                     almostfull,
  output logic                     almostempty
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

  payload_t mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic push;
  logic pop;

  // a write into a full FIFO and a read from an empty one are both dropped.
  assign push = we && !full;
  assign pop = re && !empty;

  assign empty = (count == '0);
  assign full = (count == (FIFO_DEPTH_BITS + 1)'(DEPTH));
  assign almostfull = (count >= (FIFO_DEPTH_BITS + 1)'(ALMOSTFULL_THRESHOLD));
  assign almostempty = (count <= (FIFO_DEPTH_BITS + 1)'(ALMOSTEMPTY_THRESHOLD));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (pop) begin
      dout <= mem[rd_ptr]; // read data is registered, so it shows up with valid.
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/output_queue_controller.sv
`timescale 1ns/1ps
`default_nettype none

module output_queue_controller
  import acc_out_pkg::*;
#(
  parameter int ID_QUEUE = 0
) (
  input  logic                        clk,
  input  logic                        rst_internal,
  input  logic                        start,
  input  logic [CONF_VALID_WIDTH-1:0] conf_valid,
  input  conf_word_t                  conf,
  input  logic                        available_write,
  input  logic                        ack,
  input  logic                        user_write,
  input  logic [DATA_WIDTH-1:0]       user_data,
  output logic                        user_available,
  output logic                        request_write,
  output write_req_t                  write_data,
  output logic                        has_wr_pending,
  output logic                        done
);

  logic queue_rst;
  logic conf_rd_valid;
  conf_word_t conf_rd;
  logic conf_ready;
  logic [QTD_WIDTH-1:0] qtd;
  logic [ADDR_WIDTH-1:0] addr_next;
  logic [QTD_WIDTH-1:0] count_req;
  logic [QTD_WIDTH-1:0] count_written;
  logic [QTD_WIDTH-1:0] pending;
  logic issue;
  logic fifo_re;
  logic fifo_valid;
  logic [DATA_WIDTH-1:0] fifo_dout;
  logic fifo_empty;
  logic fifo_almostfull;
  logic fifo_almostempty;

  conf_receiver #(
    .ID_QUEUE(ID_QUEUE)
  ) conf_rx (
    .clk(clk),
    .rst_internal(rst_internal),
    .conf_valid(conf_valid),
    .conf(conf),
    .conf_out_valid(conf_rd_valid),
    .conf_out(conf_rd),
    .queue_rst(queue_rst)
  );

  fifo #(
    .payload_t(logic [DATA_WIDTH-1:0]),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS),
    .ALMOSTFULL_THRESHOLD(FIFO_ALMOSTFULL),
    .ALMOSTEMPTY_THRESHOLD(FIFO_ALMOSTEMPTY)
  ) data_fifo (
    .clk(clk),
    .rst_internal(queue_rst),
    .we(user_write),
    .din(user_data),
    .re(fifo_re),
    .valid(fifo_valid),
    .dout(fifo_dout),
    .count(),
    .empty(fifo_empty),
    .full(),
    .almostfull(fifo_almostfull),
    .almostempty(fifo_almostempty)
  );

  assign user_available = !fifo_almostfull;

  // near empty, a read still in flight could take the last word, so wait for it.
  assign issue = start && conf_ready && (count_req < qtd) && available_write &&
                 (fifo_almostempty ? (!fifo_empty && !fifo_re) : 1'b1);

  always_ff @(posedge clk) begin
    if (queue_rst) begin
      conf_ready <= 1'b0;
      qtd <= '0;
    end else if (conf_rd_valid) begin
      conf_ready <= 1'b1;
      qtd <= conf_rd.qtd;
    end
  end

  always_ff @(posedge clk) begin
    if (queue_rst) begin
      fifo_re <= 1'b0;
      count_req <= '0;
    end else begin
      fifo_re <= issue;
      if (issue) begin
        count_req <= count_req + 1'b1; // counted at issue so no extra read slips through.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (queue_rst) begin
      addr_next <= '0;
    end else if (conf_rd_valid) begin
      addr_next <= conf_rd.addr_base;
    end else if (fifo_valid) begin
      addr_next <= addr_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (queue_rst) begin
      request_write <= 1'b0;
    end else begin
      request_write <= fifo_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_valid) begin
      write_data <= '{data: fifo_dout, addr: addr_next, tag: TAG_WIDTH'(ID_QUEUE)};
    end
  end

  // Pending writes go up per request and down by a whole group per acknowledgement.
  always_ff @(posedge clk) begin
    if (queue_rst) begin
      pending <= '0;
      count_written <= '0;
    end else begin
      case ({ack, request_write})
        2'b01: pending <= pending + 1'b1;
        2'b10: pending <= pending - QTD_WIDTH'(WORDS_PER_ACK);
        2'b11: pending <= pending - QTD_WIDTH'(WORDS_PER_ACK - 1);
        default: pending <= pending;
      endcase
      if (ack) begin
        count_written <= count_written + QTD_WIDTH'(WORDS_PER_ACK);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (queue_rst) begin
      done <= 1'b0;
      has_wr_pending <= 1'b0;
    end else begin
      done <= conf_ready && start && fifo_empty && (count_written >= qtd);
      has_wr_pending <= (pending != '0);
    end
  end

endmodule

`default_nettype wire

//--- hw/write_ack_router.sv
`timescale 1ns/1ps
`default_nettype none

module write_ack_router
  import acc_out_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_internal,
  input  logic                  mem_ack_valid,
  input  logic [TAG_WIDTH-1:0]  mem_ack_tag,
  output logic [NUM_QUEUES-1:0] ack
);

  // a tag with no matching queue sets no bit, so it is simply dropped.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      ack <= '0;
    end else begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
        ack[i] <= mem_ack_valid && (mem_ack_tag == TAG_WIDTH'(i));
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter
  import acc_out_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_internal,
  input  logic [NUM_QUEUES-1:0]       request_write,
  input  write_req_t [NUM_QUEUES-1:0] write_data,
  input  logic                        mem_available,
  output logic [NUM_QUEUES-1:0]       available_write,
  output logic                        mem_request_write,
  output write_req_t                  mem_write_data
);

  logic [NUM_QUEUES-1:0] grant;
  logic fifo_we;
  write_req_t fifo_din;
  logic fifo_re;
  logic fifo_valid;
  logic fifo_empty;
  logic fifo_almostfull;
  logic head_held;
  logic head_valid;

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      grant <= NUM_QUEUES'(1);
      available_write <= '0;
    end else begin
      grant <= (grant << 1) | NUM_QUEUES'(grant[NUM_QUEUES-1]);
      // stop granting early because requests already issued still need room.
      available_write <= fifo_almostfull ? '0 : grant;
    end
  end

  // Grants are a cycle apart, so at most one queue pulses in a cycle.
  always_comb begin
    fifo_we = |request_write;
    fifo_din = '0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      if (request_write[i]) begin
        fifo_din = write_data[i];
      end
    end
  end

  fifo #(
    .payload_t(write_req_t),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS),
    .ALMOSTFULL_THRESHOLD(FIFO_ALMOSTFULL),
    .ALMOSTEMPTY_THRESHOLD(FIFO_ALMOSTEMPTY)
  ) req_fifo (
    .clk(clk),
    .rst_internal(rst_internal),
    .we(fifo_we),
    .din(fifo_din),
    .re(fifo_re),
    .valid(fifo_valid),
    .dout(mem_write_data),
    .count(),
    .empty(fifo_empty),
    .full(),
    .almostfull(fifo_almostfull),
    .almostempty()
  );

  // the FIFO output register holds the head until memory takes it.
  assign head_valid = fifo_valid || head_held;
  assign mem_request_write = head_valid && mem_available;
  assign fifo_re = !fifo_empty && (!head_valid || mem_request_write);

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      head_held <= 1'b0;
    end else begin
      head_held <= head_valid && !mem_request_write;
    end
  end

endmodule

`default_nettype wire

//--- verification/acc_output_tb.sv
`timescale 1ns/1ps
`default_nettype none

module acc_output_tb
  import acc_out_pkg::*;
();

  localparam int NUM_TESTS = 3;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int MAX_WORDS = 32;

  typedef struct packed {
    logic [NUM_QUEUES-1:0]                 mask;
    logic [NUM_QUEUES-1:0][ADDR_WIDTH-1:0] base;
    logic [NUM_QUEUES-1:0][QTD_WIDTH-1:0]  qtd;
    logic                                  stall;
  } test_row_t;

  logic clk;
  logic rst_internal;
  logic [NUM_QUEUES-1:0] start;
  logic [CONF_VALID_WIDTH-1:0] conf_valid;
  conf_word_t conf;
  logic [NUM_QUEUES-1:0] user_write;
  logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0] user_data;
  logic mem_available;
  logic mem_ack_valid;
  logic [TAG_WIDTH-1:0] mem_ack_tag;
  logic [NUM_QUEUES-1:0] user_available;
  logic mem_request_write;
  write_req_t mem_write_data;
  logic [NUM_QUEUES-1:0] has_wr_pending;
  logic [NUM_QUEUES-1:0] done;

  test_row_t table_rows [NUM_TESTS];
  string test_names [NUM_TESTS];
  logic [NUM_QUEUES-1:0] active;
  logic [NUM_QUEUES-1:0][ADDR_WIDTH-1:0] base_cur;
  int qtd_cur [NUM_QUEUES];
  int seen [NUM_QUEUES];     // memory writes observed per tag.
  int ack_cnt [NUM_QUEUES];  // acknowledgements sent per tag.
  int wr_total;              // memory writes of the current test, of any tag.
  logic [DATA_WIDTH-1:0] exp_word [NUM_QUEUES][MAX_WORDS];
  logic [31:0] rng;
  logic stall_mode;
  logic [3:0] stall_cnt;
  int errors;
  int checks;

  acc_output_top UUT (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .user_write(user_write),
    .user_data(user_data),
    .mem_available(mem_available),
    .mem_ack_valid(mem_ack_valid),
    .mem_ack_tag(mem_ack_tag),
    .user_available(user_available),
    .mem_request_write(mem_request_write),
    .mem_write_data(mem_write_data),
    .has_wr_pending(has_wr_pending),
    .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // memory is stalled for 10 of every 16 cycles in stall mode.
  always @(posedge clk) begin
    stall_cnt <= stall_cnt + 1'b1;
    mem_available <= !stall_mode || (stall_cnt < 4'd6);
  end

  // Memory model and scoreboard. One acknowledgement goes back per four writes of a tag.
  always @(posedge clk) begin : mem_model
    int t;
    mem_ack_valid <= 1'b0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (active[q] && done[q] && (seen[q] < qtd_cur[q] ||
          ack_cnt[q] * WORDS_PER_ACK < qtd_cur[q])) begin
        $display("done of queue %0d rose at %0t ns before all words were acknowledged", q,
                 $time);
        errors++;
      end
      if (active[q] && seen[q] > ack_cnt[q] * WORDS_PER_ACK) begin
        check_value($sformatf("has_wr_pending[%0d]", q), 1, has_wr_pending[q]);
      end
    end
    if (mem_request_write) begin
      t = int'(mem_write_data.tag);
      wr_total <= wr_total + 1;
      if (!mem_available) begin
        $display("memory write at %0t ns while memory was not available", $time);
        errors++;
      end
      if (t >= NUM_QUEUES || !active[t] || seen[t] >= qtd_cur[t]) begin
        $display("unexpected memory write with tag %0d at %0t ns", t, $time);
        errors++;
      end else begin
        check_value($sformatf("mem_write_data.data[tag %0d]", t), exp_word[t][seen[t]],
                    mem_write_data.data);
        check_value($sformatf("mem_write_data.addr[tag %0d]", t),
                    base_cur[t] + ADDR_WIDTH'(seen[t]), mem_write_data.addr);
        seen[t] <= seen[t] + 1;
        if (seen[t] % WORDS_PER_ACK == WORDS_PER_ACK - 1) begin
          mem_ack_valid <= 1'b1;
          mem_ack_tag <= TAG_WIDTH'(t);
          ack_cnt[t] <= ack_cnt[t] + 1;
        end
      end
    end
  end

  task automatic send_conf(input logic [CONF_VALID_WIDTH-1:0] code,
                           input logic [ADDR_WIDTH-1:0] base_addr,
                           input logic [QTD_WIDTH-1:0] words, input logic [7:0] id);
    @(posedge clk);
    conf_valid <= code;
    conf <= '{addr_base: base_addr, qtd: words, queue_id: id};
    @(posedge clk);
    conf_valid <= '0;
  endtask

  task automatic clear_queues();
    @(posedge clk);
    start <= '0;
    send_conf(CONF_CODE_RESET, '0, '0, '0);
    repeat (3) @(posedge clk); // the queue-local reset lands two cycles after the code.
  endtask

  task automatic run_row(input int idx);
    test_row_t row;
    int err_start;
    int cycles;
    int total;
    int pushed [NUM_QUEUES];
    logic finished;
    logic [NUM_QUEUES-1:0] wr;
    row = table_rows[idx];
    err_start = errors;
    total = 0;
    clear_queues();
    @(posedge clk);
    active <= row.mask;
    stall_mode <= row.stall;
    wr_total <= 0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      base_cur[q] <= row.base[q];
      qtd_cur[q] <= int'(row.qtd[q]);
      seen[q] <= 0;
      ack_cnt[q] <= 0;
      pushed[q] = 0;
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (row.mask[q]) send_conf(CONF_CODE_OUT_DATA, row.base[q], row.qtd[q], 8'(q));
    end
    @(posedge clk);
    start <= row.mask;
    cycles = 0;
    finished = 1'b0;
    while (!finished && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      wr = '0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (row.mask[q] && pushed[q] < int'(row.qtd[q]) && user_available[q]) begin
          rng = xorshift(rng);
          exp_word[q][pushed[q]] = rng;
          user_data[q] <= rng;
          wr[q] = 1'b1;
          pushed[q]++;
        end
      end
      user_write <= wr;
      finished = 1'b1;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (row.mask[q] && !(seen[q] == int'(row.qtd[q]) && done[q])) finished = 1'b0;
      end
      cycles++;
    end
    user_write <= '0;
    if (!finished) begin
      $display("timeout: test %s did not finish in %0d cycles", test_names[idx], cycles);
      errors++;
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (row.mask[q]) begin
        check_value($sformatf("write count[tag %0d]", q), row.qtd[q], seen[q]);
        check_value($sformatf("has_wr_pending[%0d]", q), 0, has_wr_pending[q]);
      end
    end
    total = wr_total;
    check_value("total write count", row.qtd[0] * row.mask[0] + row.qtd[1] * row.mask[1],
                total);
    $display("%s: %0d writes, %0d errors", test_names[idx], total, errors - err_start);
  endtask

  // foreign ids and other codes must leave both queues idle.
  task automatic run_filter_test();
    int err_start;
    int cycles;
    err_start = errors;
    check_value("done", {NUM_QUEUES{1'b1}}, done);
    @(posedge clk);
    active <= '0;
    send_conf(CONF_CODE_RESET, '0, '0, '0);
    repeat (3) @(posedge clk);
    check_value("done", 0, done);
    // three words are written but their group is never acknowledged.
    @(posedge clk);
    active <= NUM_QUEUES'(1);
    base_cur[0] <= 32'h7000;
    qtd_cur[0] <= 8;
    seen[0] <= 0;
    ack_cnt[0] <= 0;
    send_conf(CONF_CODE_OUT_DATA, 32'h7000, 16'd8, 8'd0);
    @(posedge clk);
    start <= NUM_QUEUES'(1);
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      rng = xorshift(rng);
      exp_word[0][i] = rng;
      user_data[0] <= rng;
      user_write <= NUM_QUEUES'(1);
    end
    @(posedge clk);
    user_write <= '0;
    cycles = 0;
    while (seen[0] < 3 && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (seen[0] < 3) begin
      $display("timeout: only %0d of 3 words of queue 0 reached memory", seen[0]);
      errors++;
    end
    check_value("has_wr_pending", NUM_QUEUES'(1), has_wr_pending);
    @(posedge clk);
    active <= '0;
    send_conf(CONF_CODE_RESET, '0, '0, '0);
    repeat (3) @(posedge clk);
    check_value("has_wr_pending", 0, has_wr_pending);
    send_conf(CONF_CODE_OUT_DATA, 32'h4000, 16'd8, 8'd5);
    send_conf(2'd3, 32'h5000, 16'd8, 8'd0);
    send_conf(2'd0, 32'h6000, 16'd8, 8'd1);
    @(posedge clk);
    start <= '1;
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      rng = xorshift(rng);
      user_write <= '1;
      user_data <= {rng, ~rng};
    end
    @(posedge clk);
    user_write <= '0;
    check_value("user_available", {NUM_QUEUES{1'b1}}, user_available); // eleven words are in.
    repeat (40) @(posedge clk);
    check_value("user_available", 0, user_available);
    check_value("done", 0, done);
    clear_queues();
    $display("conf_filter: %0d errors", errors - err_start);
  endtask

  initial begin
    rst_internal = 1'b1;
    start = '0;
    conf_valid = '0;
    conf = '0;
    user_write = '0;
    user_data = '0;
    mem_available = 1'b0;
    mem_ack_valid = 1'b0;
    mem_ack_tag = '0;
    active = '0;
    stall_mode = 1'b0;
    stall_cnt = '0;
    base_cur = '0;
    qtd_cur = '{default: 0};
    seen = '{default: 0};
    ack_cnt = '{default: 0};
    wr_total = 0;
    rng = 32'd99;
    errors = 0;
    checks = 0;
    test_names[0] = "single_queue";
    table_rows[0] = '{2'b01, {32'h0, 32'h1000}, {16'd0, 16'd8}, 1'b0};
    test_names[1] = "both_queues";
    table_rows[1] = '{2'b11, {32'h8000, 32'h2000}, {16'd16, 16'd12}, 1'b0};
    test_names[2] = "memory_stall";
    table_rows[2] = '{2'b11, {32'h9000, 32'h3000}, {16'd8, 16'd20}, 1'b1};
    repeat (8) @(posedge clk);
    rst_internal <= 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_row(i);
    end
    run_filter_test();
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
